// File: vlog.f
+incdir+dv
design/elevator_pkg.sv
design/call_register.sv
design/dispatch.sv
design/car_control.sv
design/elevator_top.sv
dv/elevator_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run the testbench and judge the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module elevator_tb \
	-f vlog.f -o elevator_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/elevator_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: dv/elevator_ref.svh
// reference model functions for the elevator testbench
// hall button masking, next stop prediction and xorshift generator
`ifndef ELEVATOR_REF_SVH
`define ELEVATOR_REF_SVH

function automatic logic [floor_count-1:0] one_hot(int f);
	return floor_count'(1) << f;
endfunction

// top floor has no up button, ground floor no down button
function automatic logic [floor_count-1:0] mask_calls(logic [floor_count-1:0] in_calls,
		logic [floor_count-1:0] up_calls, logic [floor_count-1:0] down_calls);
	logic [floor_count-1:0] up_ok;
	logic [floor_count-1:0] down_ok;
	up_ok                = up_calls;
	up_ok[floor_count-1] = 1'b0;
	down_ok              = down_calls;
	down_ok[0]           = 1'b0;
	return in_calls | up_ok | down_ok;
endfunction

// serve here first, then nearest call ahead, then nearest behind
function automatic floor_t next_stop(floor_t here, logic going_up, logic [floor_count-1:0] calls);
	int above;
	int below;
	above = -1;
	below = -1;
	if (calls[here])
		return here;
	for (int f = floor_count - 1; f > int'(here); f--)
		if (calls[f])
			above = f;	// ends on the nearest one
	for (int f = 0; f < int'(here); f++)
		if (calls[f])
			below = f;
	if (going_up && above >= 0)
		return floor_t'(above);
	if (!going_up && below >= 0)
		return floor_t'(below);
	if (above >= 0)
		return floor_t'(above);
	if (below >= 0)
		return floor_t'(below);
	return here;	// nothing to serve
endfunction

function automatic logic [31:0] xorshift(logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

// File: dv/elevator_tb.sv
// testbench for the elevator controller
// directed scenarios, random traffic and a next stop checking process
`timescale 1ns/1ps

module elevator_tb import elevator_pkg::*; ();

	logic                   clk;
	logic                   reset;
	logic                   open_btn;
	logic [floor_count-1:0] btn_in;
	logic [floor_count-1:0] btn_up_out;
	logic [floor_count-1:0] btn_down_out;
	engine_t                engine;
	door_t                  door;
	floor_t                 level_display;

	int                     errors;
	int                     checks;
	logic [floor_count-1:0] model_pending;	// calls the DUT should hold
	floor_t                 model_floor;	// floor of the last stop
	logic                   model_dir;	// 1 means up
	floor_t                 stop_log[$];
	logic [31:0]            seed;

	`include "elevator_ref.svh"

	elevator_top DUT (
		.clk           (clk),
		.reset         (reset),
		.open_btn      (open_btn),
		.btn_in        (btn_in),
		.btn_up_out    (btn_up_out),
		.btn_down_out  (btn_down_out),
		.engine        (engine),
		.door          (door),
		.level_display (level_display)
	);

	always #50 clk = ~clk;

	task automatic check_value(string what, int got, int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic report_timeout(string why);
		errors++;
		$display("timeout: %s", why);
	endtask

	// caller sits on a falling edge, buttons held for one cycle
	task automatic press_buttons(logic [floor_count-1:0] in_calls,
			logic [floor_count-1:0] up_calls, logic [floor_count-1:0] down_calls);
		btn_in       = in_calls;
		btn_up_out   = up_calls;
		btn_down_out = down_calls;
		@(negedge clk);
		btn_in       = '0;
		btn_up_out   = '0;
		btn_down_out = '0;
	endtask

	task automatic wait_door(door_t target, int limit, string what);
		int n;
		n = 0;
		while (door != target && n < limit) begin
			n++;
			@(posedge clk);
			#1;
		end
		if (door != target)
			report_timeout(what);
	endtask

	task automatic wait_engine(engine_t target, int limit, string what);
		int n;
		n = 0;
		while (engine != target && n < limit) begin
			n++;
			@(posedge clk);
			#1;
		end
		if (engine != target)
			report_timeout(what);
	endtask

	task automatic wait_stops(int count, int limit, string what);
		int n;
		n = 0;
		while (stop_log.size() < count && n < limit) begin
			n++;
			@(posedge clk);
			#1;
		end
		if (stop_log.size() < count)
			report_timeout(what);
	endtask

	// car parked with the door shut and nothing left to serve
	task automatic wait_rest(int limit, string what);
		int n;
		n = 0;
		while (!(engine == engine_idle && door == door_idle && model_pending == '0) &&
				n < limit) begin
			n++;
			@(posedge clk);
			#1;
		end
		if (!(engine == engine_idle && door == door_idle && model_pending == '0))
			report_timeout(what);
	endtask

	// presses only while the door is busy or the car has no work
	task automatic wait_press_slot(int limit, string what);
		int n;
		n = 0;
		while (!(door != door_idle || (model_pending == '0 && engine == engine_idle)) &&
				n < limit) begin
			n++;
			@(negedge clk);
		end
		if (!(door != door_idle || (model_pending == '0 && engine == engine_idle)))
			report_timeout(what);
	endtask

	task automatic door_sequence();
		int open_cycles;
		int close_cycles;
		open_cycles  = 0;
		close_cycles = 0;
		while (door == door_open && open_cycles < 100) begin
			open_cycles++;
			@(posedge clk);
			#1;
		end
		while (door == door_close && close_cycles < 100) begin
			close_cycles++;
			@(posedge clk);
			#1;
		end
		check_value("door open cycles", open_cycles, door_hold_cycles);
		check_value("door close cycles", close_cycles, door_close_cycles);
		check_value("door after closing", int'(door), int'(door_idle));
	endtask

	// compares each door opening with the predicted stop, keeps the call model
	initial begin : compare_proc
		door_t  prev_door;
		floor_t prev_level;
		floor_t expect_floor;
		logic   opened;
		int     step;
		prev_door     = door_idle;
		prev_level    = '0;
		model_pending = '0;
		model_floor   = '0;
		model_dir     = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			if (reset) begin
				if (door != door_idle)
					check_value("engine with door active", int'(engine), int'(engine_idle));
				step = int'(level_display) - int'(prev_level);
				if (step != 0)
					check_value("floor step size", (step < 0) ? -step : step, 1);
				opened = (door == door_open) && (prev_door == door_idle);
				if (opened) begin
					expect_floor = next_stop(model_floor, model_dir, model_pending);
					check_value("door opening floor", int'(level_display), int'(expect_floor));
					if (expect_floor > model_floor)
						model_dir = 1'b1;
					else if (expect_floor < model_floor)
						model_dir = 1'b0;
					model_floor = expect_floor;
					stop_log.push_back(level_display);
				end
				// press latched on this edge, clear at the opened floor wins
				model_pending = model_pending | mask_calls(btn_in, btn_up_out, btn_down_out);
				if (opened)
					model_pending[model_floor] = 1'b0;
				prev_door  = door;
				prev_level = level_display;
			end
		end
	end

	initial begin : main_flow
		int     up_cycles;
		int     since_step;
		int     guard;
		int     pick;
		int     kind;
		logic   seen_step;
		floor_t last_level;
		clk          = 1'b0;
		reset        = 1'b0;
		open_btn     = 1'b0;
		btn_in       = '0;
		btn_up_out   = '0;
		btn_down_out = '0;
		errors       = 0;
		checks       = 0;
		seed         = 32'h7863;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;

		@(posedge clk);
		#1;
		check_value("engine after reset", int'(engine), int'(engine_idle));
		check_value("door after reset", int'(door), int'(door_idle));
		check_value("display after reset", int'(level_display), 0);

		// single in-car call from floor 0 to floor 5
		@(negedge clk);
		press_buttons(one_hot(5), '0, '0);
		wait_engine(engine_up, 20, "car did not start toward floor 5");
		up_cycles  = 0;
		since_step = 0;
		guard      = 0;
		seen_step  = 1'b0;
		last_level = level_display;
		while (engine == engine_up && guard < 200) begin
			up_cycles++;
			guard++;
			@(posedge clk);
			#1;
			since_step++;
			if (level_display != last_level) begin
				if (seen_step)
					check_value("cycles per floor", since_step, travel_cycles);
				seen_step  = 1'b1;
				since_step = 0;
				last_level = level_display;
			end
		end
		check_value("engine up cycles", up_cycles, 5 * travel_cycles);
		check_value("arrival floor", int'(level_display), 5);
		check_value("door at arrival", int'(door), int'(door_open));
		check_value("engine at arrival", int'(engine), int'(engine_idle));
		door_sequence();

		// missing hall buttons at floor 3
		@(negedge clk);
		press_buttons(one_hot(3), '0, '0);
		wait_rest(200, "car did not settle at floor 3");
		check_value("parked floor", int'(level_display), 3);
		@(negedge clk);
		press_buttons('0, one_hot(floor_count - 1), one_hot(0));
		for (guard = 0; guard < 40; guard++) begin
			@(posedge clk);
			#1;
			check_value("engine after masked press", int'(engine), int'(engine_idle));
			check_value("door after masked press", int'(door), int'(door_idle));
		end

		// collective order, late call behind the car
		@(negedge clk);
		press_buttons(one_hot(0), '0, '0);
		wait_rest(200, "car did not return to floor 0");
		stop_log.delete();
		@(negedge clk);
		press_buttons(one_hot(2) | one_hot(6), one_hot(4), '0);
		wait_stops(2, 300, "car did not stop at floor 4");
		wait_engine(engine_up, 50, "car did not leave floor 4");
		@(negedge clk);
		press_buttons(one_hot(1), '0, '0);
		wait_rest(400, "collective run did not finish");
		check_value("stops in collective run", stop_log.size(), 4);
		if (stop_log.size() == 4) begin
			check_value("first stop", int'(stop_log[0]), 2);
			check_value("second stop", int'(stop_log[1]), 4);
			check_value("third stop", int'(stop_log[2]), 6);
			check_value("fourth stop", int'(stop_log[3]), 1);
		end

		// open button while the door is closing
		@(negedge clk);
		press_buttons(one_hot(1), '0, '0);
		wait_door(door_close, 40, "door never started closing at floor 1");
		@(negedge clk);
		open_btn = 1'b1;
		@(negedge clk);
		open_btn = 1'b0;
		check_value("door after open button", int'(door), int'(door_open));
		check_value("engine after open button", int'(engine), int'(engine_idle));
		door_sequence();

		// random traffic
		@(negedge clk);
		for (int i = 0; i < 40; i++) begin
			wait_press_slot(600, "no chance to press a random call");
			seed = xorshift(seed);
			pick = int'(seed[4:2]);
			kind = int'(seed[1:0]);
			press_buttons((kind == 0) ? one_hot(pick) : '0,
				(kind == 1) ? one_hot(pick) : '0,
				(kind >= 2) ? one_hot(pick) : '0);
			repeat (int'(seed[9:6])) @(negedge clk);
		end
		wait_rest(4000, "random calls were not all served");

		@(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: design/elevator_top.sv
// elevator controller top level
// call register, dispatcher and car FSM wired to the pins
`timescale 1ns/1ps

module elevator_top import elevator_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   open_btn,
	input  logic [floor_count-1:0] btn_in,		// in-car buttons
	input  logic [floor_count-1:0] btn_up_out,	// hall up
	input  logic [floor_count-1:0] btn_down_out,	// hall down
	output engine_t                engine,
	output door_t                  door,
	output floor_t                 level_display
);

	logic [floor_count-1:0] pending;
	floor_t                 floor;
	logic                   clear_call;
	logic                   start_move;
	logic                   stop_here;
	logic                   move_up;
	logic                   move_down;

	call_register u_call_register (
		.clk          (clk),
		.reset        (reset),
		.btn_in       (btn_in),
		.btn_up_out   (btn_up_out),
		.btn_down_out (btn_down_out),
		.clear_call   (clear_call),
		.floor        (floor),
		.pending      (pending)
	);

	dispatch u_dispatch (
		.clk        (clk),
		.reset      (reset),
		.pending    (pending),
		.floor      (floor),
		.start_move (start_move),
		.stop_here  (stop_here),
		.move_up    (move_up),
		.move_down  (move_down)
	);

	car_control u_car_control (
		.clk           (clk),
		.reset         (reset),
		.open_btn      (open_btn),
		.stop_here     (stop_here),
		.move_up       (move_up),
		.move_down     (move_down),
		.floor         (floor),
		.clear_call    (clear_call),
		.start_move    (start_move),
		.engine        (engine),
		.door          (door),
		.level_display (level_display)
	);

endmodule

// File: design/car_control.sv
// car FSM with floor counter and shared travel/door timer
// drives engine, door, display and the clear and start pulses
`timescale 1ns/1ps

module car_control import elevator_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    open_btn,
	input  logic    stop_here,
	input  logic    move_up,
	input  logic    move_down,
	output floor_t  floor,
	output logic    clear_call,
	output logic    start_move,
	output engine_t engine,
	output door_t   door,
	output floor_t  level_display
);

	car_state_t state;
	timer_t     timer;
	logic       floor_step;
	logic       travel_last;
	logic       hold_done;
	logic       close_done;

	assign floor_step  = (timer == timer_t'(travel_cycles - 2));
	assign travel_last = (timer == timer_t'(travel_cycles - 1));
	assign hold_done   = (timer == timer_t'(door_hold_cycles - 1));
	assign close_done  = (timer == timer_t'(door_close_cycles - 1));

	// door opens on a call here, at rest or at the end of a floor
	assign clear_call = stop_here &&
		((state == st_rest) || (state == st_travel && travel_last));

	assign start_move = (state == st_rest) && !open_btn && (move_up || move_down);

	assign level_display = floor;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= st_rest;
			timer  <= '0;
			floor  <= '0;
			engine <= engine_idle;
			door   <= door_idle;
		end else begin
			case (state)
				st_rest: begin
					timer <= '0;
					if (open_btn || stop_here) begin
						state <= st_open;
						door  <= door_open;
					end else if (move_up) begin
						state  <= st_travel;
						engine <= engine_up;
					end else if (move_down) begin
						state  <= st_travel;
						engine <= engine_down;
					end
				end

				st_travel: begin
					if (travel_last) begin
						timer <= '0;
						if (stop_here) begin
							state  <= st_open;	// arrived at a call
							engine <= engine_idle;
							door   <= door_open;
						end
					end else begin
						timer <= timer + 1'b1;
						if (floor_step) begin
							if (engine == engine_up)
								floor <= floor + 1'b1;
							else
								floor <= floor - 1'b1;
						end
					end
				end

				st_open: begin
					if (hold_done) begin
						state <= st_close;
						door  <= door_close;
						timer <= '0;
					end else begin
						timer <= timer + 1'b1;
					end
				end

				st_close: begin
					if (open_btn) begin
						state <= st_open;	// reopen, hold starts over
						door  <= door_open;
						timer <= '0;
					end else if (close_done) begin
						state <= st_rest;
						door  <= door_idle;
						timer <= '0;
					end else begin
						timer <= timer + 1'b1;
					end
				end

				default: begin
					state  <= st_rest;
					timer  <= '0;
					engine <= engine_idle;
					door   <= door_idle;
				end
			endcase
		end
	end

	a_door_engine: assert property (@(posedge clk) disable iff (!reset)
		(door != door_idle) |-> (engine == engine_idle))
		else $error("engine running with door active");

	// floor moves by one with the engine and never wraps
	a_floor_range: assert property (@(posedge clk) disable iff (!reset)
		$changed(floor) |->
			(($past(engine) == engine_up) ?
				($past(floor) != floor_t'(floor_count - 1)) :
				($past(floor) != '0)))
		else $error("floor left its range");

endmodule

// File: design/dispatch.sv
// direction keeping dispatcher for collective scheduling
// stop, up or down decision from pending calls and current floor
`timescale 1ns/1ps

module dispatch import elevator_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [floor_count-1:0] pending,
	input  floor_t                 floor,
	input  logic                   start_move,
	output logic                   stop_here,
	output logic                   move_up,
	output logic                   move_down
);

	logic dir_up;		// 1 up, 0 down
	logic calls_above;
	logic calls_below;

	always_comb begin
		calls_above = 1'b0;
		calls_below = 1'b0;
		for (int i = 0; i < floor_count; i++) begin
			if (i > int'(floor))
				calls_above = calls_above | pending[i];
			if (i < int'(floor))
				calls_below = calls_below | pending[i];
		end
	end

	assign stop_here = pending[floor];

	always_comb begin
		move_up   = 1'b0;
		move_down = 1'b0;
		if (!stop_here) begin
			if (dir_up) begin
				if (calls_above)
					move_up = 1'b1;		// keep going up
				else if (calls_below)
					move_down = 1'b1;	// reverse
			end else begin
				if (calls_below)
					move_down = 1'b1;
				else if (calls_above)
					move_up = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			dir_up <= 1'b1;
		end else if (start_move) begin
			dir_up <= move_up;	// remember the chosen way
		end
	end

	a_one_direction: assert property (@(posedge clk) disable iff (!reset)
		!(move_up && move_down))
		else $error("dispatch asks for both directions");

endmodule

// File: design/call_register.sv
// call register for in-car and hall buttons
// latches presses, masks missing hall buttons, clears served floor
`timescale 1ns/1ps

module call_register import elevator_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [floor_count-1:0] btn_in,
	input  logic [floor_count-1:0] btn_up_out,
	input  logic [floor_count-1:0] btn_down_out,
	input  logic                   clear_call,
	input  floor_t                 floor,
	output logic [floor_count-1:0] pending
);

	logic [floor_count-1:0] call_in;
	logic [floor_count-1:0] call_up;
	logic [floor_count-1:0] call_down;
	logic [floor_count-1:0] up_valid;
	logic [floor_count-1:0] down_valid;
	logic [floor_count-1:0] clear_vec;
	logic [floor_count-1:0] press_any;

	assign up_valid   = {1'b0, {(floor_count-1){1'b1}}};	// no up button on top floor
	assign down_valid = {{(floor_count-1){1'b1}}, 1'b0};	// no down button on ground

	assign clear_vec = clear_call ? (floor_count'(1) << floor) : '0;

	assign press_any = btn_in | (btn_up_out & up_valid) | (btn_down_out & down_valid);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			call_in   <= '0;
			call_up   <= '0;
			call_down <= '0;
		end else begin
			// clear beats a press at the same floor
			call_in   <= (call_in | btn_in) & ~clear_vec;
			call_up   <= (call_up | (btn_up_out & up_valid)) & ~clear_vec;
			call_down <= (call_down | (btn_down_out & down_valid)) & ~clear_vec;
		end
	end

	assign pending = call_in | call_up | call_down;

	// served floor drops out of pending on the following cycle
	a_clear_served: assert property (@(posedge clk) disable iff (!reset)
		clear_call |=> (!pending[$past(floor)] || press_any[$past(floor)]))
		else $error("call at served floor still pending after clear");

endmodule

// File: design/elevator_pkg.sv
// shared constants and types for the elevator controller
// floor and timer types, engine, door and car state enums
package elevator_pkg;

	localparam int floor_count = 8;

	typedef logic [2:0] floor_t;

	// timing in clock cycles
	localparam int travel_cycles     = 4;	// engine drive per floor
	localparam int door_hold_cycles  = 6;	// door fully open
	localparam int door_close_cycles = 2;	// closing phase

	typedef logic [3:0] timer_t;

	typedef enum logic [1:0] {
		engine_idle = 2'd0,
		engine_down = 2'd1,
		engine_up   = 2'd2
	} engine_t;

	typedef enum logic [1:0] {
		door_idle  = 2'd0,
		door_open  = 2'd1,
		door_close = 2'd2
	} door_t;

	typedef enum logic [2:0] {
		st_rest,
		st_travel,
		st_open,
		st_close
	} car_state_t;

endpackage
